//--- smpc_top.f
common/smpc_pkg.sv
host/smpc_host_port.sv
command/smpc_cmd_ctrl.sv
command/smpc_reset_ctl.sv
oreg/smpc_oreg_ram.sv
oreg/smpc_oreg_source.sv
hdl/smpc_top.sv
+incdir+testbench
testbench/tb_smpc_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f smpc_top.f --top-module tb_smpc_top -o sim_smpc

out=$(./obj_dir/sim_smpc)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

//--- testbench/tb_smpc_model.svh
`ifndef TB_SMPC_MODEL_SVH
`define TB_SMPC_MODEL_SVH

// Word addresses on A
localparam logic [5:0] W_IREG0  = 6'h00;
localparam logic [5:0] W_IREG1  = 6'h01;
localparam logic [5:0] W_IREG2  = 6'h02;
localparam logic [5:0] W_IREG3  = 6'h03;
localparam logic [5:0] W_COMREG = 6'h0F;
localparam logic [5:0] W_OREG0  = 6'h10;
localparam logic [5:0] W_SR     = 6'h30;
localparam logic [5:0] W_SF     = 6'h31;

localparam logic [7:0] C_MSHON   = 8'h00;
localparam logic [7:0] C_SSHON   = 8'h02;
localparam logic [7:0] C_SSHOFF  = 8'h03;
localparam logic [7:0] C_SNDON   = 8'h06;
localparam logic [7:0] C_SNDOFF  = 8'h07;
localparam logic [7:0] C_CDON    = 8'h08;
localparam logic [7:0] C_CDOFF   = 8'h09;
localparam logic [7:0] C_SYSRES  = 8'h0D;
localparam logic [7:0] C_INTBACK = 8'h10;
localparam logic [7:0] C_SETSMEM = 8'h17;
localparam logic [7:0] C_NMIREQ  = 8'h18;
localparam logic [7:0] C_RESENAB = 8'h19;
localparam logic [7:0] C_RESDISA = 8'h1A;

logic [31:0] lcg_state = 32'd42;

// Expected DUT state
logic       exp_mshres = 1'b0;
logic       exp_mshnmi = 1'b0;
logic       exp_sshres = 1'b0;
logic       exp_sshnmi = 1'b0;
logic       exp_sysres = 1'b0;
logic       exp_sndres = 1'b0;
logic       exp_cdres  = 1'b0;
logic       exp_resd   = 1'b1;
logic [2:0] exp_sr_hi  = 3'b000;
logic [7:0] exp_ireg1  = 8'h00;
logic [7:0] exp_smem [4] = '{default: 8'h00};
logic [7:0] exp_oreg [32];
logic [31:0] oreg_known = 32'd0; // RAM has no reset
logic [3:0] ac_val = 4'd0;
int         exp_irq_pulses = 0;

function automatic logic [31:0] next_rand();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

task automatic write_bus(input logic [5:0] word, input logic [7:0] data);
	@(posedge CLK);
	a <= word;
	di <= data;
	cs_n <= 1'b0;
	rw_n <= 1'b1;
	@(posedge CLK);
	rw_n <= 1'b0; // Write strobe
	@(posedge CLK);
	cs_n <= 1'b1;
	rw_n <= 1'b1;
endtask

task automatic read_bus(input logic [5:0] word, output logic [7:0] data);
	@(posedge CLK);
	a <= word;
	rw_n <= 1'b1;
	cs_n <= 1'b0;
	@(posedge CLK);
	@(negedge CLK);
	data = dout;
	@(posedge CLK);
	cs_n <= 1'b1;
endtask

// INTBACK status byte from the current expected state
function automatic logic [7:0] status_byte(input logic [4:0] idx);
	logic [7:0] b;
	case (idx)
		5'd0:  b = {1'b0, exp_resd, 6'd0};
		5'd1:  b = 8'h20;
		5'd2:  b = 8'h22;
		5'd3:  b = 8'h01;
		5'd9:  b = {4'd0, ac_val};
		5'd10: b = {4'h3, ~exp_mshnmi, 1'b1, ~exp_sysres, ~exp_sndres};
		5'd11: b = {1'b0, ~exp_cdres, 6'd0};
		5'd12: b = exp_smem[0];
		5'd13: b = exp_smem[1];
		5'd14: b = exp_smem[2];
		5'd15: b = exp_smem[3];
		5'd31: b = C_INTBACK;
		default: b = 8'h00;
	endcase
	return b;
endfunction

task automatic model_apply(input logic [7:0] code, input logic [7:0] i0, input logic [7:0] i1,
		input logic [7:0] i2, input logic [7:0] i3);
	int k;
	exp_ireg1 = i1;
	case (code)
		C_MSHON: begin
			exp_mshres = 1'b1;
			exp_mshnmi = 1'b1;
		end
		C_SSHON: begin
			exp_sshres = 1'b1;
			exp_sshnmi = 1'b1;
		end
		C_SSHOFF: begin
			exp_sshres = 1'b0;
			exp_sshnmi = 1'b1;
		end
		C_SNDON:  exp_sndres = 1'b1;
		C_SNDOFF: exp_sndres = 1'b0;
		C_CDON:   exp_cdres = 1'b1;
		C_CDOFF:  exp_cdres = 1'b0;
		C_SYSRES: begin // Lines are released again at the end
			exp_mshres = 1'b1;
			exp_mshnmi = 1'b1;
			exp_sshres = 1'b1;
			exp_sshnmi = 1'b1;
			exp_sysres = 1'b1;
			exp_sndres = 1'b1;
			exp_cdres  = 1'b1;
		end
		C_NMIREQ:  exp_mshnmi = 1'b1;
		C_RESENAB: exp_resd = 1'b0;
		C_RESDISA: exp_resd = 1'b1;
		C_SETSMEM: begin
			exp_smem[0] = i0;
			exp_smem[1] = i1;
			exp_smem[2] = i2;
			exp_smem[3] = i3;
		end
		C_INTBACK: begin
			if (i2 == 8'hF0 && i0[0]) begin
				for (k = 0; k < 32; k++)
					exp_oreg[5'(k)] = status_byte(5'(k));
				oreg_known = '1;
				exp_sr_hi = 3'b010;
				exp_irq_pulses++;
			end
		end
		default: ;
	endcase
	exp_oreg[31] = code; // Every command echoes
	oreg_known[31] = 1'b1;
endtask

task automatic issue_cmd(input logic [7:0] code, input logic [7:0] i0, input logic [7:0] i1,
		input logic [7:0] i2, input logic [7:0] i3);
	logic [7:0] sf_val;
	int polls;
	write_bus(W_IREG0, i0);
	write_bus(W_IREG1, i1);
	write_bus(W_IREG2, i2);
	write_bus(W_IREG3, i3);
	write_bus(W_COMREG, code);
	write_bus(W_SF, 8'h01);
	polls = 0;
	sf_val = 8'h01;
	while (sf_val[0] && polls < MAX_POLLS) begin
		read_bus(W_SF, sf_val);
		polls++;
	end
	assert (!sf_val[0]) else begin
		errors++;
		$display("SF was still set after %0d polls for command %h", polls, code);
	end
endtask

`endif

//--- testbench/tb_smpc_top.sv
`timescale 1ns/1ns

module tb_smpc_top;

	localparam int CLK_PERIOD  = 100;
	localparam int N_RANDOM    = 60;
	localparam int N_DIRECTED  = 2;
	localparam int MAX_POLLS   = 2000;
	localparam int BUS_CLKS    = 3;
	localparam int WATCHDOG_NS = (N_RANDOM + N_DIRECTED) * MAX_POLLS * BUS_CLKS * CLK_PERIOD;

	logic       CLK;
	logic       RST_N;
	logic [6:1] a;
	logic [7:0] di;
	logic [7:0] dout;
	logic       cs_n;
	logic       rw_n;
	logic [3:0] ac;
	logic       mshres_n;
	logic       mshnmi_n;
	logic       sshres_n;
	logic       sshnmi_n;
	logic       sysres_n;
	logic       sndres_n;
	logic       cdres_n;
	logic       mirq_n;

	int errors = 0;
	int irq_pulses = 0;
	int irq_len = 0;
	int low_run = 0;

	`include "tb_smpc_model.svh"

	smpc_top #(
		.WAIT_SCALE (1)
	) dut_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.a        (a),
		.di       (di),
		.dout     (dout),
		.cs_n     (cs_n),
		.rw_n     (rw_n),
		.ac       (ac),
		.mshres_n (mshres_n),
		.mshnmi_n (mshnmi_n),
		.sshres_n (sshres_n),
		.sshnmi_n (sshnmi_n),
		.sysres_n (sysres_n),
		.sndres_n (sndres_n),
		.cdres_n  (cdres_n),
		.mirq_n   (mirq_n)
	);

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// Length of each MIRQ_N low pulse in clocks
	always @(negedge CLK) begin
		if (RST_N) begin
			if (!mirq_n) begin
				low_run++;
			end else if (low_run != 0) begin
				irq_pulses++;
				irq_len = low_run;
				low_run = 0;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		errors++;
		$display("Timeout: the command sequence did not finish within %0d ns", WATCHDOG_NS);
		$display("Errors: %0d", errors);
		$display("Test failed");
		$finish;
	end

	task automatic check_byte(input string name, input logic [7:0] expv, input logic [7:0] got);
		assert (got === expv) else begin
			errors++;
			$display("error at %0t ns: %s expected %h got %h", $time, name, expv, got);
		end
	endtask

	task automatic check_bit(input string name, input logic expv, input logic got);
		assert (got === expv) else begin
			errors++;
			$display("error at %0t ns: %s expected %b got %b", $time, name, expv, got);
		end
	endtask

	task automatic check_lines();
		@(negedge CLK);
		check_bit("mshres_n", exp_mshres, mshres_n);
		check_bit("mshnmi_n", exp_mshnmi, mshnmi_n);
		check_bit("sshres_n", exp_sshres, sshres_n);
		check_bit("sshnmi_n", exp_sshnmi, sshnmi_n);
		check_bit("sysres_n", exp_sysres, sysres_n);
		check_bit("sndres_n", exp_sndres, sndres_n);
		check_bit("cdres_n", exp_cdres, cdres_n);
		check_bit("mirq_n", 1'b1, mirq_n);
	endtask

	task automatic check_after_cmd();
		logic [7:0] v;
		logic [4:0] idx;
		int k;
		check_lines();
		read_bus(W_SR, v);
		check_byte("SR", {exp_sr_hi, 1'b0, exp_ireg1[7:4]}, v);
		read_bus(W_SF, v);
		check_byte("SF", 8'h00, v);
		for (k = 0; k < 32; k++) begin
			idx = 5'(k);
			if (oreg_known[idx]) begin
				read_bus(W_OREG0 + {1'b0, idx}, v);
				check_byte($sformatf("OREG%0d", k), exp_oreg[idx], v);
			end
		end
		assert (irq_pulses == exp_irq_pulses) else begin
			errors++;
			$display("error at %0t ns: mirq_n pulse count expected %0d got %0d",
				$time, exp_irq_pulses, irq_pulses);
		end
		assert (irq_pulses == 0 || irq_len == 2) else begin
			errors++;
			$display("error at %0t ns: mirq_n low cycles expected 2 got %0d", $time, irq_len);
		end
	endtask

	task automatic run_cmd(input logic [7:0] code, input logic [7:0] i0, input logic [7:0] i1,
			input logic [7:0] i2, input logic [7:0] i3, input logic [3:0] ac_new);
		@(posedge CLK);
		ac <= ac_new;
		ac_val = ac_new;
		issue_cmd(code, i0, i1, i2, i3);
		model_apply(code, i0, i1, i2, i3);
		check_after_cmd();
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		logic [7:0]  code;
		logic [7:0]  i2;
		logic [7:0]  v;
		int          n;
		RST_N = 1'b0;
		a = 6'd0;
		di = 8'h00;
		cs_n = 1'b1;
		rw_n = 1'b1;
		ac = 4'd0;
		repeat (2) @(posedge CLK);
		RST_N <= 1'b1;
		@(posedge CLK);

		check_lines();
		read_bus(W_SR, v);
		check_byte("SR", 8'h00, v);
		read_bus(W_SF, v);
		check_byte("SF", 8'h00, v);

		r = next_rand();
		s = next_rand();
		run_cmd(C_SETSMEM, r[7:0], r[15:8], r[23:16], r[31:24], s[3:0]);
		run_cmd(C_INTBACK, 8'h01, s[15:8], 8'hF0, s[31:24], s[7:4]);

		for (n = 0; n < N_RANDOM; n++) begin
			r = next_rand();
			s = next_rand();
			case (r[19:16])
				4'd0:  code = C_MSHON;
				4'd1:  code = C_SSHON;
				4'd2:  code = C_SSHOFF;
				4'd3:  code = C_SNDON;
				4'd4:  code = C_SNDOFF;
				4'd5:  code = C_CDON;
				4'd6:  code = C_CDOFF;
				4'd7:  code = C_SYSRES;
				4'd9:  code = C_SETSMEM;
				4'd10: code = C_NMIREQ;
				4'd11: code = C_RESENAB;
				4'd12: code = C_RESDISA;
				4'd15: code = {1'b1, r[30:24]}; // Outside the command table
				default: code = C_INTBACK;
			endcase
			i2 = s[23:16];
			if (code == C_INTBACK) begin
				if (r[21:20] != 2'd0)
					i2 = 8'hF0;
				else if (i2 == 8'hF0)
					i2 = 8'h0F;
			end
			run_cmd(code, {s[7:1], s[7:1] != 7'd0 || r[22]}, s[15:8], i2, s[31:24], r[3:0]);
		end

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- hdl/smpc_top.sv
`timescale 1ns/1ns

module smpc_top #(
	parameter int WAIT_SCALE = 1
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [6:1] a,
	input  logic [7:0] di,
	output logic [7:0] dout,
	input  logic       cs_n,
	input  logic       rw_n,
	input  logic [3:0] ac,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sysres_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n
);
	import smpc_pkg::*;

	logic [7:0]         comreg;
	logic [7:0]         ireg0;
	logic [7:0]         ireg1;
	logic [7:0]         ireg2;
	logic [7:0]         ireg3;
	logic               cmd_start;
	logic [OREG_AW-1:0] oreg_raddr;
	logic [7:0]         oreg_q;
	logic [2:0]         sr_hi;
	logic               cmd_exec;
	logic               cmd_end;
	logic               oreg_we;
	logic [OREG_AW-1:0] oreg_idx;
	logic [7:0]         oreg_wdata;
	logic               resd;

	smpc_host_port host_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.a          (a),
		.di         (di),
		.cs_n       (cs_n),
		.rw_n       (rw_n),
		.sf_clr     (cmd_end),
		.sr_hi      (sr_hi),
		.oreg_q     (oreg_q),
		.dout       (dout),
		.comreg     (comreg),
		.ireg0      (ireg0),
		.ireg1      (ireg1),
		.ireg2      (ireg2),
		.ireg3      (ireg3),
		.cmd_start  (cmd_start),
		.oreg_raddr (oreg_raddr)
	);

	smpc_cmd_ctrl #(
		.WAIT_SCALE (WAIT_SCALE)
	) ctrl_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cmd_start (cmd_start),
		.comreg    (comreg),
		.ireg0     (ireg0),
		.ireg2     (ireg2),
		.cmd_exec  (cmd_exec),
		.cmd_end   (cmd_end),
		.oreg_we   (oreg_we),
		.oreg_idx  (oreg_idx),
		.sr_hi     (sr_hi),
		.mirq_n    (mirq_n)
	);

	smpc_reset_ctl rst_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.comreg   (comreg),
		.cmd_exec (cmd_exec),
		.cmd_end  (cmd_end),
		.mshres_n (mshres_n),
		.mshnmi_n (mshnmi_n),
		.sshres_n (sshres_n),
		.sshnmi_n (sshnmi_n),
		.sysres_n (sysres_n),
		.sndres_n (sndres_n),
		.cdres_n  (cdres_n),
		.resd     (resd)
	);

	smpc_oreg_source src_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.comreg     (comreg),
		.cmd_exec   (cmd_exec),
		.ireg0      (ireg0),
		.ireg1      (ireg1),
		.ireg2      (ireg2),
		.ireg3      (ireg3),
		.oreg_idx   (oreg_idx),
		.ac         (ac),
		.resd       (resd),
		.mshnmi_n   (mshnmi_n),
		.sysres_n   (sysres_n),
		.sndres_n   (sndres_n),
		.cdres_n    (cdres_n),
		.oreg_wdata (oreg_wdata)
	);

	smpc_oreg_ram ram_i (
		.CLK   (CLK),
		.waddr (oreg_idx),
		.wdata (oreg_wdata),
		.we    (oreg_we),
		.raddr (oreg_raddr),
		.q     (oreg_q)
	);

endmodule

//--- oreg/smpc_oreg_source.sv
`timescale 1ns/1ns

module smpc_oreg_source (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic [7:0]                   comreg,
	input  logic                         cmd_exec,
	input  logic [7:0]                   ireg0,
	input  logic [7:0]                   ireg1,
	input  logic [7:0]                   ireg2,
	input  logic [7:0]                   ireg3,
	input  logic [smpc_pkg::OREG_AW-1:0] oreg_idx,
	input  logic [3:0]                   ac,
	input  logic                         resd,
	input  logic                         mshnmi_n,
	input  logic                         sysres_n,
	input  logic                         sndres_n,
	input  logic                         cdres_n,
	output logic [7:0]                   oreg_wdata
);
	import smpc_pkg::*;

	logic [7:0] smem [4];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			smem <= '{default: 8'h00};
		end else if (cmd_exec && comreg == SETSMEM) begin
			smem[0] <= ireg0;
			smem[1] <= ireg1;
			smem[2] <= ireg2;
			smem[3] <= ireg3;
		end
	end

	always_comb begin
		case (oreg_idx)
			5'd0:  oreg_wdata = {1'b0, resd, 6'd0}; // STE and clock fields stay 0
			5'd1:  oreg_wdata = 8'h20;
			5'd2:  oreg_wdata = 8'h22;
			5'd3:  oreg_wdata = 8'h01;
			5'd9:  oreg_wdata = {4'd0, ac}; // Area code
			5'd10: oreg_wdata = {4'h3, ~mshnmi_n, 1'b1, ~sysres_n, ~sndres_n};
			5'd11: oreg_wdata = {1'b0, ~cdres_n, 6'd0};
			5'd12, 5'd13, 5'd14, 5'd15: oreg_wdata = smem[oreg_idx[1:0]];
			OREG_CMD_IDX: oreg_wdata = comreg;
			default: oreg_wdata = 8'h00;
		endcase
	end

endmodule

//--- oreg/smpc_oreg_ram.sv
`timescale 1ns/1ns

module smpc_oreg_ram (
	input  logic                         CLK,
	input  logic [smpc_pkg::OREG_AW-1:0] waddr,
	input  logic [7:0]                   wdata,
	input  logic                         we,
	input  logic [smpc_pkg::OREG_AW-1:0] raddr,
	output logic [7:0]                   q
);
	import smpc_pkg::*;

	logic [7:0] mem [OREG_DEPTH];

	always_ff @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign q = mem[raddr]; // Host read path, no output register

endmodule

//--- command/smpc_reset_ctl.sv
`timescale 1ns/1ns

module smpc_reset_ctl (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [7:0] comreg,
	input  logic       cmd_exec,
	input  logic       cmd_end,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sysres_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       resd
);
	import smpc_pkg::*;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mshres_n <= 1'b0;
			mshnmi_n <= 1'b0;
			sshres_n <= 1'b0;
			sshnmi_n <= 1'b0;
			sysres_n <= 1'b0;
			sndres_n <= 1'b0;
			cdres_n  <= 1'b0;
			resd     <= 1'b1;
		end else if (cmd_exec) begin
			case (comreg)
				MSHON: begin
					mshres_n <= 1'b1;
					mshnmi_n <= 1'b1;
				end
				SSHON: begin
					sshres_n <= 1'b1;
					sshnmi_n <= 1'b1;
				end
				SSHOFF: begin
					sshres_n <= 1'b0;
					sshnmi_n <= 1'b1;
				end
				SNDON:  sndres_n <= 1'b1;
				SNDOFF: sndres_n <= 1'b0;
				CDON:   cdres_n  <= 1'b1;
				CDOFF:  cdres_n  <= 1'b0;
				SYSRES: begin
					mshres_n <= 1'b0;
					mshnmi_n <= 1'b0;
					sshres_n <= 1'b0;
					sshnmi_n <= 1'b0;
					sysres_n <= 1'b0;
					sndres_n <= 1'b0;
					cdres_n  <= 1'b0;
				end
				NMIREQ:  mshnmi_n <= 1'b0;
				RESENAB: resd     <= 1'b0;
				RESDISA: resd     <= 1'b1;
				default: ;
			endcase
		end else if (cmd_end) begin
			case (comreg)
				SYSRES: begin // Release after the reset pulse
					mshres_n <= 1'b1;
					mshnmi_n <= 1'b1;
					sshres_n <= 1'b1;
					sshnmi_n <= 1'b1;
					sysres_n <= 1'b1;
					sndres_n <= 1'b1;
					cdres_n  <= 1'b1;
				end
				NMIREQ:  mshnmi_n <= 1'b1;
				default: ;
			endcase
		end
	end

	a_sysres_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd_end && comreg == SYSRES |-> !sysres_n);

endmodule

//--- command/smpc_cmd_ctrl.sv
`timescale 1ns/1ns

module smpc_cmd_ctrl #(
	parameter int WAIT_SCALE = 1
) (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         cmd_start,
	input  logic [7:0]                   comreg,
	input  logic [7:0]                   ireg0,
	input  logic [7:0]                   ireg2,
	output logic                         cmd_exec,
	output logic                         cmd_end,
	output logic                         oreg_we,
	output logic [smpc_pkg::OREG_AW-1:0] oreg_idx,
	output logic [2:0]                   sr_hi,
	output logic                         mirq_n
);
	import smpc_pkg::*;

	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_START = 3'd1;
	localparam logic [2:0] ST_WAIT  = 3'd2;
	localparam logic [2:0] ST_EXEC  = 3'd3;
	localparam logic [2:0] ST_END   = 3'd4;

	logic [2:0]  state;
	logic [15:0] wait_cnt;
	logic [15:0] base_wait;
	logic [15:0] wait_len;
	logic        wait_hit;
	logic        intback_ok;
	logic        sweep;
	logic        pend;
	logic        irq_hold;

	assign intback_ok = (ireg2 == INTBACK_KEY) && ireg0[0];
	assign wait_len   = 16'(base_wait * WAIT_SCALE);
	assign oreg_we    = (state == ST_EXEC);

	always_comb begin
		base_wait = 16'd0;
		wait_hit  = 1'b1;
		case (comreg)
			MSHON, SSHON, SSHOFF, SNDON, SNDOFF: base_wait = WAIT_POWER;
			CDON, CDOFF:                         base_wait = WAIT_CD;
			SYSRES:                              base_wait = WAIT_SYSRES;
			SETSMEM:                             base_wait = WAIT_SMEM;
			NMIREQ, RESENAB, RESDISA:            base_wait = WAIT_NMI;
			INTBACK: begin
				base_wait = WAIT_INTBACK;
				wait_hit  = intback_ok; // Rejected INTBACK only echoes
			end
			default: wait_hit = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state    <= ST_IDLE;
			wait_cnt <= 16'd0;
			oreg_idx <= '0;
			sweep    <= 1'b0;
			pend     <= 1'b0;
			cmd_exec <= 1'b0;
			cmd_end  <= 1'b0;
			sr_hi    <= 3'b000;
			mirq_n   <= 1'b1;
			irq_hold <= 1'b0;
		end else begin
			cmd_exec <= 1'b0;
			cmd_end  <= 1'b0;

			if (irq_hold)
				irq_hold <= 1'b0;
			else if (!mirq_n)
				mirq_n <= 1'b1;

			if (cmd_start && state != ST_IDLE)
				pend <= 1'b1;

			case (state)
				ST_IDLE: begin
					if (cmd_start || pend) begin
						pend  <= 1'b0;
						state <= ST_START;
					end
				end
				ST_START: begin
					sweep <= (comreg == INTBACK) && intback_ok;
					if (wait_hit) begin
						wait_cnt <= wait_len - 16'd1;
						state    <= ST_WAIT;
					end else begin
						oreg_idx <= OREG_CMD_IDX;
						cmd_exec <= 1'b1;
						state    <= ST_EXEC;
					end
				end
				ST_WAIT: begin
					if (wait_cnt == 16'd0) begin
						oreg_idx <= sweep ? '0 : OREG_CMD_IDX; // Status block starts at OREG0
						cmd_exec <= 1'b1;
						state    <= ST_EXEC;
					end else begin
						wait_cnt <= wait_cnt - 16'd1;
					end
				end
				ST_EXEC: begin
					if (oreg_idx == OREG_CMD_IDX) begin
						cmd_end <= 1'b1;
						state   <= ST_END;
						if (sweep) begin
							sr_hi    <= SR_STATUS_DONE;
							mirq_n   <= 1'b0;
							irq_hold <= 1'b1;
						end
					end else begin
						oreg_idx <= oreg_idx + 5'd1;
					end
				end
				ST_END: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_we_cmd_slot: assert property (@(posedge CLK) disable iff (!RST_N)
		oreg_we && !sweep |-> oreg_idx == OREG_CMD_IDX);

	a_exec_end_excl: assert property (@(posedge CLK) disable iff (!RST_N)
		!(cmd_exec && cmd_end));

endmodule

//--- host/smpc_host_port.sv
`timescale 1ns/1ns

module smpc_host_port (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic [6:1]                   a,
	input  logic [7:0]                   di,
	input  logic                         cs_n,
	input  logic                         rw_n,
	input  logic                         sf_clr,
	input  logic [2:0]                   sr_hi,
	input  logic [7:0]                   oreg_q,
	output logic [7:0]                   dout,
	output logic [7:0]                   comreg,
	output logic [7:0]                   ireg0,
	output logic [7:0]                   ireg1,
	output logic [7:0]                   ireg2,
	output logic [7:0]                   ireg3,
	output logic                         cmd_start,
	output logic [smpc_pkg::OREG_AW-1:0] oreg_raddr
);
	import smpc_pkg::*;

	logic       rw_n_old;
	logic       cs_n_old;
	logic       wr_hit;
	logic       rd_hit;
	logic [6:0] addr;
	logic [5:0] word_ofs;
	logic [7:0] ireg [7];
	logic       sf;
	logic [7:0] rd_data;

	assign addr   = {a, 1'b1};
	assign wr_hit = !rw_n && rw_n_old && !cs_n; // RW_N fall inside a select
	assign rd_hit = !cs_n && cs_n_old && rw_n;  // CS_N fall with read

	assign word_ofs   = a - OREG_BASE_WORD;
	assign oreg_raddr = word_ofs[OREG_AW-1:0];

	assign ireg0 = ireg[0];
	assign ireg1 = ireg[1];
	assign ireg2 = ireg[2];
	assign ireg3 = ireg[3];

	always_comb begin
		if (addr >= ADDR_OREG_FIRST && addr <= ADDR_OREG_LAST)
			rd_data = oreg_q;
		else if (addr == ADDR_SR)
			rd_data = {sr_hi, 1'b0, ireg[1][7:4]};
		else if (addr == ADDR_SF)
			rd_data = {7'd0, sf};
		else
			rd_data = 8'h00;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old  <= 1'b1;
			cs_n_old  <= 1'b1;
			ireg      <= '{default: 8'h00};
			comreg    <= 8'h00;
			cmd_start <= 1'b0;
			sf        <= 1'b0;
			dout      <= 8'h00;
		end else begin
			rw_n_old  <= rw_n;
			cs_n_old  <= cs_n;
			cmd_start <= 1'b0;

			if (sf_clr)
				sf <= 1'b0;

			if (wr_hit) begin
				case (addr)
					ADDR_IREG0: ireg[0] <= di;
					ADDR_IREG1: ireg[1] <= di;
					ADDR_IREG2: ireg[2] <= di;
					ADDR_IREG3: ireg[3] <= di;
					ADDR_IREG4: ireg[4] <= di;
					ADDR_IREG5: ireg[5] <= di;
					ADDR_IREG6: ireg[6] <= di;
					ADDR_COMREG: begin
						comreg    <= di;
						cmd_start <= 1'b1;
					end
					ADDR_SF: begin
						if (di[0])
							sf <= 1'b1;
					end
					default: ;
				endcase
			end

			if (rd_hit)
				dout <= rd_data;
		end
	end

	a_start_single: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd_start |=> !cmd_start);

endmodule

//--- common/smpc_pkg.sv
package smpc_pkg;

	typedef enum logic [7:0] {
		MSHON   = 8'h00,
		SSHON   = 8'h02,
		SSHOFF  = 8'h03,
		SNDON   = 8'h06,
		SNDOFF  = 8'h07,
		CDON    = 8'h08,
		CDOFF   = 8'h09,
		SYSRES  = 8'h0D,
		INTBACK = 8'h10,
		SETSMEM = 8'h17,
		NMIREQ  = 8'h18,
		RESENAB = 8'h19,
		RESDISA = 8'h1A
	} cmd_code_t;

	// Byte addresses as {A, 1'b1}
	localparam logic [6:0] ADDR_IREG0      = 7'h01;
	localparam logic [6:0] ADDR_IREG1      = 7'h03;
	localparam logic [6:0] ADDR_IREG2      = 7'h05;
	localparam logic [6:0] ADDR_IREG3      = 7'h07;
	localparam logic [6:0] ADDR_IREG4      = 7'h09;
	localparam logic [6:0] ADDR_IREG5      = 7'h0B;
	localparam logic [6:0] ADDR_IREG6      = 7'h0D;
	localparam logic [6:0] ADDR_COMREG     = 7'h1F;
	localparam logic [6:0] ADDR_SR         = 7'h61;
	localparam logic [6:0] ADDR_SF         = 7'h63;
	localparam logic [6:0] ADDR_OREG_FIRST = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST  = 7'h5F;

	localparam int OREG_AW    = 5;
	localparam int OREG_DEPTH = 32;

	localparam logic [OREG_AW-1:0] OREG_CMD_IDX   = 5'd31; // Command echo slot
	localparam logic [5:0]         OREG_BASE_WORD = 6'h10; // OREG0 word address on A

	// Base waits in clocks
	localparam logic [15:0] WAIT_POWER   = 16'd120;
	localparam logic [15:0] WAIT_CD      = 16'd159;
	localparam logic [15:0] WAIT_SYSRES  = 16'd400;
	localparam logic [15:0] WAIT_INTBACK = 16'd500;
	localparam logic [15:0] WAIT_SMEM    = 16'd159;
	localparam logic [15:0] WAIT_NMI     = 16'd127;

	localparam logic [7:0] INTBACK_KEY    = 8'hF0;
	localparam logic [2:0] SR_STATUS_DONE = 3'b010;

endpackage
